// File: src.f
verilog/qv_pkg.sv
verilog/qv_decoder.sv
verilog/qv_prefetch.sv
verilog/qv_regfile.sv
verilog/qv_alu.sv
verilog/qv_cpu.sv
bench/tb_qv_cpu.sv

// File: Bender.yml
package:
  name: qv_cpu

sources:
  - files:
      - verilog/qv_pkg.sv
  - files:
      - verilog/qv_decoder.sv
      - verilog/qv_prefetch.sv
      - verilog/qv_regfile.sv
      - verilog/qv_alu.sv
      - verilog/qv_cpu.sv
  - target: test
    files:
      - bench/tb_qv_cpu.sv

// File: bench/tb_qv_cpu.sv
`timescale 1ns/1ps

module tb_qv_cpu;

    // Each program row holds the instruction word and, for a store, the expected request
    typedef struct packed {
        logic [31:0] word;
        logic        is_store;
        logic [23:0] addr;
        logic [31:0] data;
    } row_t;

    typedef struct packed {
        logic [23:0] addr;
        logic [31:0] data;
    } store_t;

    logic        clk;
    logic        rstn;
    logic [23:1] instr_addr;
    logic        instr_fetch_restart;
    logic        instr_fetch_stall;
    logic [15:0] instr_data_in;
    logic        instr_ready;
    logic [23:0] data_addr;
    logic        data_read;
    logic        data_write;
    logic [31:0] data_out;
    logic        data_ready;
    logic [31:0] data_in;
    logic        debug_instr_complete;
    logic [3:0]  debug_rd;

    row_t        prog[$];
    store_t      seen[$];
    logic [22:0] exp_restart[$];
    int          exp_rd[$];         // Destination of each executed instruction, -1 for a store
    logic [31:0] xr[16];            // Architectural register model
    logic [31:0] dmem[logic [23:0]];
    logic [31:0] lfsr;
    logic        fetching;
    logic        busy;
    logic [2:0]  wait_left;
    store_t      req;
    store_t      obs;
    logic        req_write;

    qv_cpu #(.NUM_REGS(16)) dut_i (
        .clk                  (clk),
        .rstn                 (rstn),
        .instr_addr           (instr_addr),
        .instr_fetch_restart  (instr_fetch_restart),
        .instr_fetch_stall    (instr_fetch_stall),
        .instr_data_in        (instr_data_in),
        .instr_ready          (instr_ready),
        .data_addr            (data_addr),
        .data_read            (data_read),
        .data_write           (data_write),
        .data_out             (data_out),
        .data_ready           (data_ready),
        .data_in              (data_in),
        .debug_instr_complete (debug_instr_complete),
        .debug_rd             (debug_rd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32 + x^22 + x^2 + x + 1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] alu_ref(input logic sub, input logic [2:0] f3,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return sub ? a - b : a + b;
        endcase
    endfunction

    function automatic logic [15:0] fetch_half(input logic [22:0] ha);
        int unsigned idx;
        idx = int'(ha >> 1);
        if (idx >= prog.size()) return 16'h0000;  // Anything past the program decodes as a no-op
        return ha[0] ? prog[idx].word[31:16] : prog[idx].word[15:0];
    endfunction

    function automatic logic [31:0] read_word(input logic [23:0] addr);
        if (dmem.exists(addr)) return dmem[addr];
        return {8'h3C, addr} ^ {addr[15:0], addr[23:8]};
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic abort(input string why);
        $display("Error at %0t ns: %s", $time, why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic append_row(input logic [31:0] word, input logic is_store,
                              input logic [23:0] addr, input logic [31:0] data);
        row_t r;
        r.word     = word;
        r.is_store = is_store;
        r.addr     = addr;
        r.data     = data;
        prog.push_back(r);
    endtask

    task automatic set_reg(input logic [3:0] rd, input logic [31:0] v);
        exp_rd.push_back(int'(rd));
        if (rd != 4'd0) xr[rd] = v;
    endtask

    task automatic lui(input logic [3:0] rd, input logic [19:0] imm20);
        append_row({imm20, 1'b0, rd, 7'b0110111}, 1'b0, '0, '0);
        set_reg(rd, {imm20, 12'h000});
    endtask

    task automatic op_imm(input logic [2:0] f3, input logic [3:0] rd, input logic [3:0] rs1,
                          input logic [11:0] imm);
        append_row({imm, 1'b0, rs1, f3, 1'b0, rd, 7'b0010011}, 1'b0, '0, '0);
        set_reg(rd, alu_ref(1'b0, f3, xr[rs1], sext12(imm)));
    endtask

    task automatic op_reg(input logic sub, input logic [2:0] f3, input logic [3:0] rd,
                          input logic [3:0] rs1, input logic [3:0] rs2);
        append_row({1'b0, sub, 6'd0, rs2, 1'b0, rs1, f3, 1'b0, rd, 7'b0110011}, 1'b0, '0, '0);
        set_reg(rd, alu_ref(sub, f3, xr[rs1], xr[rs2]));
    endtask

    task automatic load_word(input logic [3:0] rd, input logic [3:0] rs1,
                             input logic [11:0] imm);
        logic [31:0] addr;
        addr = xr[rs1] + sext12(imm);
        append_row({imm, 1'b0, rs1, 3'b010, 1'b0, rd, 7'b0000011}, 1'b0, '0, '0);
        set_reg(rd, read_word(addr[23:0]));
    endtask

    task automatic store_word(input logic [3:0] rs2, input logic [3:0] rs1,
                              input logic [11:0] imm);
        logic [31:0] addr;
        addr = xr[rs1] + sext12(imm);
        append_row({imm[11:5], 1'b0, rs2, 1'b0, rs1, 3'b010, imm[4:0], 7'b0100011},
                   1'b1, addr[23:0], xr[rs2]);
        exp_rd.push_back(-1);
    endtask

    task automatic jump_link(input logic [3:0] rd, input logic [20:0] off);
        logic [31:0] pc;
        logic [31:0] target;
        pc     = 32'(prog.size()) * 4;
        target = pc + {{11{off[20]}}, off};
        append_row({off[20], off[10:1], off[11], off[19:12], 1'b0, rd, 7'b1101111},
                   1'b0, '0, '0);
        set_reg(rd, pc + 32'd4);
        exp_restart.push_back(target[23:1]);
    endtask

    task automatic load_const(input logic [3:0] rd, input logic [31:0] v);
        lui(rd, v[31:12] + 20'(v[11]));  // ADDI sign-extends, so round the upper part
        op_imm(3'b000, rd, rd, v[11:0]);
    endtask

    task automatic build_program();
        op_imm(3'b000, 4'd2, 4'd0, 12'h100);  // Store base
        op_imm(3'b000, 4'd9, 4'd0, 12'h200);  // Load base
        load_const(4'd3, rand_bits(32));
        load_const(4'd4, rand_bits(32));
        store_word(4'd3, 4'd2, 12'd0);
        store_word(4'd4, 4'd2, 12'd4);
        op_reg(1'b0, 3'b000, 4'd5, 4'd3, 4'd4);
        store_word(4'd5, 4'd2, 12'd8);
        op_reg(1'b1, 3'b000, 4'd6, 4'd3, 4'd4);
        store_word(4'd6, 4'd2, 12'd12);
        op_reg(1'b0, 3'b111, 4'd7, 4'd3, 4'd4);
        store_word(4'd7, 4'd2, 12'd16);
        op_reg(1'b0, 3'b110, 4'd8, 4'd3, 4'd4);
        store_word(4'd8, 4'd2, 12'd20);
        op_reg(1'b0, 3'b100, 4'd8, 4'd8, 4'd3);
        store_word(4'd8, 4'd2, 12'd24);
        op_imm(3'b100, 4'd7, 4'd3, 12'(rand_bits(12)));
        op_imm(3'b110, 4'd7, 4'd7, 12'(rand_bits(12)));
        op_imm(3'b111, 4'd7, 4'd7, 12'(rand_bits(12)));
        store_word(4'd7, 4'd2, 12'd28);
        // Carry and borrow through all eight nibbles
        op_imm(3'b000, 4'd10, 4'd0, 12'hFFF);
        op_imm(3'b000, 4'd11, 4'd0, 12'h001);
        op_reg(1'b0, 3'b000, 4'd12, 4'd10, 4'd11);
        store_word(4'd12, 4'd2, 12'd32);
        op_reg(1'b1, 3'b000, 4'd13, 4'd0, 4'd11);
        store_word(4'd13, 4'd2, 12'd36);
        load_word(4'd14, 4'd9, 12'd0);
        op_imm(3'b000, 4'd14, 4'd14, 12'(rand_bits(12)));
        store_word(4'd14, 4'd2, 12'd40);
        load_word(4'd15, 4'd9, 12'd4);
        op_reg(1'b0, 3'b000, 4'd15, 4'd15, 4'd3);
        store_word(4'd15, 4'd2, 12'd44);
        op_imm(3'b000, 4'd0, 4'd3, 12'h123);
        store_word(4'd0, 4'd2, 12'd48);
        jump_link(4'd1, 21'd12);
        append_row({12'h7FF, 5'd0, 3'b000, 5'd5, 7'b0010011}, 1'b0, '0, '0);  // Never executes
        append_row({7'd0, 5'd5, 5'd2, 3'b010, 5'd0, 7'b0100011}, 1'b0, '0, '0);
        store_word(4'd1, 4'd2, 12'd52);
        store_word(4'd5, 4'd2, 12'd56);
    endtask

    task automatic wait_store(input int n);
        int cycles;
        cycles = 0;
        while (seen.size() == 0 && cycles < 400) begin
            @(posedge clk);
            cycles++;
        end
        if (seen.size() == 0) abort($sformatf("no store request %0d within 400 cycles", n));
    endtask

    task automatic wait_retired();
        int cycles;
        cycles = 0;
        while (exp_rd.size() != 0 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_rd.size() != 0) abort("the last instructions never signalled completion");
    endtask

    // Halfwords follow instr_addr, which always names the next one the buffer takes
    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (instr_fetch_restart === 1'b1) begin
                fetching = 1'b1;
                if (exp_restart.size() == 0) abort("fetch restart came when none was due");
                else check(32'(instr_addr), 32'(exp_restart.pop_front()), "restart address");
            end
            instr_ready   = fetching && !instr_fetch_stall;
            instr_data_in = fetch_half(instr_addr);
        end
    end

    // Instructions complete in program order with one pulse each
    initial begin
        int want;
        forever begin
            @(posedge clk);
            #2;
            if (debug_instr_complete === 1'b1) begin
                if (exp_rd.size() == 0) begin
                    abort("an instruction completed when none was due");
                end else begin
                    want = exp_rd.pop_front();
                    if (want >= 0) begin
                        check(32'(debug_rd), 32'(want), "rd of completed instruction");
                    end
                end
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (data_ready) begin
                data_ready = 1'b0;
                busy       = 1'b0;
            end else if (data_read === 1'b1 || data_write === 1'b1) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = 3'(rand_bits(3));
                    req.addr  = data_addr;
                    req.data  = data_out;
                    req_write = data_write;
                end else begin
                    check(32'(data_addr), 32'(req.addr), "data_addr held during request");
                    check(32'(data_write), 32'(req_write), "data_write held during request");
                    check(32'(data_read), 32'(!req_write), "data_read held during request");
                    if (req_write) check(data_out, req.data, "data_out held during request");
                end
                if (wait_left == 3'd0) begin
                    data_ready = 1'b1;
                    if (data_write) begin
                        dmem[data_addr] = data_out;
                        obs.addr        = data_addr;
                        obs.data        = data_out;
                        seen.push_back(obs);
                    end else begin
                        data_in = read_word(data_addr);
                    end
                end else begin
                    wait_left = wait_left - 3'd1;
                end
            end
        end
    end

    initial begin
        store_t st;
        int     n;
        lfsr          = 32'd73307;
        fetching      = 1'b0;
        busy          = 1'b0;
        rstn          = 1'b0;
        instr_data_in = '0;
        instr_ready   = 1'b0;
        data_in       = '0;
        data_ready    = 1'b0;
        foreach (xr[i]) xr[i] = '0;
        dmem[24'h000200] = rand_bits(32);
        dmem[24'h000204] = rand_bits(32);
        exp_restart.push_back(23'd0);
        build_program();
        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;
        n = 0;
        foreach (prog[i]) begin
            if (prog[i].is_store) begin
                wait_store(n);
                st = seen.pop_front();
                check(32'(st.addr), 32'(prog[i].addr), $sformatf("address of store %0d", n));
                check(st.data, prog[i].data, $sformatf("data of store %0d", n));
                n++;
            end
        end
        wait_retired();
        if (exp_restart.size() != 0) begin
            abort("the restart at the JAL target never came");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: verilog/qv_cpu.sv
`timescale 1ns/1ps

module qv_cpu import qv_pkg::*; #(
    parameter int NUM_REGS = 16
) (
    input  logic            clk,
    input  logic            rstn,

    output logic [23:1]     instr_addr,
    output logic            instr_fetch_restart,
    output logic            instr_fetch_stall,
    input  logic [15:0]     instr_data_in,
    input  logic            instr_ready,

    output logic [23:0]     data_addr,
    output logic            data_read,
    output logic            data_write,
    output logic [XLEN-1:0] data_out,
    input  logic            data_ready,
    input  logic [XLEN-1:0] data_in,

    output logic            debug_instr_complete,
    output logic [3:0]      debug_rd
);

    localparam logic [2:0] LAST_SLICE = 3'(NUM_PASS_CYCLES - 1);

    typedef enum logic [1:0] {S_IDLE, S_PASS, S_MEM_WAIT, S_LOAD_WB} state_e;

    state_e          state;
    logic [2:0]      counter;
    qv_decoded_t     dec;
    qv_decoded_t     inst;
    logic [XLEN-1:0] instr_word;
    logic            instr_avail;
    logic [23:0]     fetch_pc;
    logic [23:0]     inst_pc;
    logic [XLEN-1:0] pc_word;
    logic [XLEN-1:0] load_q;
    logic [23:1]     jal_target;
    logic            issue;
    logic            last;
    logic            is_mem;
    logic            redirect;
    logic            store_done;
    logic            wr_en;
    qv_nibble_t      rs1_nib;
    qv_nibble_t      rs2_nib;
    qv_nibble_t      a_nib;
    qv_nibble_t      b_nib;
    qv_nibble_t      y_nib;
    qv_nibble_t      wr_nib;

    qv_prefetch u_prefetch (
        .clk                 (clk),
        .rstn                (rstn),
        .instr_data_in       (instr_data_in),
        .instr_ready         (instr_ready),
        .consume             (issue),
        .redirect            (redirect),
        .redirect_addr       (jal_target),
        .instr_word          (instr_word),
        .instr_avail         (instr_avail),
        .pc                  (fetch_pc),
        .instr_addr          (instr_addr),
        .instr_fetch_restart (instr_fetch_restart),
        .instr_fetch_stall   (instr_fetch_stall)
    );

    qv_decoder u_decoder (
        .instr_word (instr_word),
        .dec        (dec)
    );

    qv_regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
        .clk     (clk),
        .counter (counter),
        .rs1     (inst.rs1),
        .rs2     (inst.rs2),
        .rd      (inst.rd),
        .wr_en   (wr_en),
        .wr_nib  (wr_nib),
        .rs1_nib (rs1_nib),
        .rs2_nib (rs2_nib)
    );

    qv_alu u_alu (
        .clk     (clk),
        .rstn    (rstn),
        .counter (counter),
        .fn      (inst.alu_fn),
        .a_nib   (a_nib),
        .b_nib   (b_nib),
        .y_nib   (y_nib)
    );

    assign issue      = state == S_IDLE && instr_avail;
    assign last       = counter == LAST_SLICE;
    assign is_mem     = inst.op inside {OP_LOAD, OP_STORE};
    assign redirect   = state == S_PASS && last && inst.op == OP_JAL;
    assign pc_word    = {{(XLEN-24){1'b0}}, inst_pc};
    assign jal_target = inst_pc[23:1] + inst.imm[23:1];

    // Operand selection per instruction class
    always_comb begin
        a_nib = rs1_nib;
        b_nib = inst.imm[counter*NIBBLE_W +: NIBBLE_W];
        case (inst.op)
            OP_ALU_REG: b_nib = rs2_nib;
            OP_JAL: begin
                a_nib = pc_word[counter*NIBBLE_W +: NIBBLE_W];
                b_nib = (counter == 3'd0) ? qv_nibble_t'(4) : '0;
            end
            default: ;
        endcase
    end

    assign wr_en  = (state == S_PASS && inst.op inside {OP_LUI, OP_ALU_IMM, OP_ALU_REG, OP_JAL})
                    || state == S_LOAD_WB;
    assign wr_nib = (state == S_LOAD_WB) ? load_q[counter*NIBBLE_W +: NIBBLE_W] : y_nib;

    assign debug_instr_complete = store_done
                                  || (last && ((state == S_PASS && !is_mem) || state == S_LOAD_WB));
    assign debug_rd = inst.rd;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= S_IDLE;
            counter    <= '0;
            inst       <= '0;
            data_read  <= 1'b0;
            data_write <= 1'b0;
            store_done <= 1'b0;
        end else begin
            store_done <= 1'b0;
            counter    <= (state == S_PASS || state == S_LOAD_WB) ? counter + 3'd1 : 3'd0;
            case (state)
                S_IDLE: begin
                    if (issue) begin
                        inst  <= dec;
                        state <= S_PASS;
                    end
                end
                S_PASS: begin
                    if (last) begin
                        if (is_mem) begin
                            data_read  <= inst.op == OP_LOAD;
                            data_write <= inst.op == OP_STORE;
                            state      <= S_MEM_WAIT;
                        end else begin
                            state <= S_IDLE;  // Illegal ops end here too, having written nothing
                        end
                    end
                end
                S_MEM_WAIT: begin
                    if (data_ready) begin
                        data_read  <= 1'b0;
                        data_write <= 1'b0;
                        store_done <= data_write;
                        state      <= data_read ? S_LOAD_WB : S_IDLE;
                    end
                end
                default: begin
                    if (last) state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) inst_pc <= fetch_pc;
        if (state == S_MEM_WAIT && data_ready) load_q <= data_in;
        if (state == S_PASS && is_mem) begin
            // Address bits above 23 are not driven out
            if (counter < 3'd6) data_addr[counter*NIBBLE_W +: NIBBLE_W] <= y_nib;
            if (inst.op == OP_STORE) data_out[counter*NIBBLE_W +: NIBBLE_W] <= rs2_nib;
        end
    end

endmodule

// File: verilog/qv_alu.sv
`timescale 1ns/1ps

module qv_alu import qv_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic [2:0] counter,
    input  qv_alu_fn_e fn,
    input  qv_nibble_t a_nib,
    input  qv_nibble_t b_nib,
    output qv_nibble_t y_nib
);

    logic              carry_q;
    logic              carry_in;
    qv_nibble_t        b_eff;
    logic [NIBBLE_W:0] sum;

    // Subtract is a plus not b plus one, the one entering at slice 0
    assign carry_in = (counter == 3'd0) ? (fn == ALU_SUB) : carry_q;
    assign b_eff    = (fn == ALU_SUB) ? ~b_nib : b_nib;
    assign sum      = {1'b0, a_nib} + {1'b0, b_eff} + {{NIBBLE_W{1'b0}}, carry_in};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            carry_q <= 1'b0;
        end else begin
            carry_q <= sum[NIBBLE_W];
        end
    end

    always_comb begin
        case (fn)
            ALU_ADD, ALU_SUB: y_nib = sum[NIBBLE_W-1:0];
            ALU_AND:          y_nib = a_nib & b_nib;
            ALU_OR:           y_nib = a_nib | b_nib;
            ALU_XOR:          y_nib = a_nib ^ b_nib;
            default:          y_nib = b_nib;
        endcase
    end

endmodule

// File: verilog/qv_regfile.sv
`timescale 1ns/1ps

module qv_regfile import qv_pkg::*; #(
    parameter int NUM_REGS = 16
) (
    input  logic       clk,
    input  logic [2:0] counter,
    input  logic [3:0] rs1,
    input  logic [3:0] rs2,
    input  logic [3:0] rd,
    input  logic       wr_en,
    input  qv_nibble_t wr_nib,
    output qv_nibble_t rs1_nib,
    output qv_nibble_t rs2_nib
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            rs1_ok;
    logic            rs2_ok;
    logic            rd_ok;

    // x0 and indices beyond the implemented registers read as zero
    assign rs1_ok = rs1 != 4'd0 && int'(rs1) < NUM_REGS;
    assign rs2_ok = rs2 != 4'd0 && int'(rs2) < NUM_REGS;
    assign rd_ok  = rd != 4'd0 && int'(rd) < NUM_REGS;

    assign rs1_nib = rs1_ok ? regs[rs1][counter*NIBBLE_W +: NIBBLE_W] : '0;
    assign rs2_nib = rs2_ok ? regs[rs2][counter*NIBBLE_W +: NIBBLE_W] : '0;

    // Same slice is read and written in one cycle, so rd may equal rs1 or rs2
    always_ff @(posedge clk) begin
        if (wr_en && rd_ok) begin
            regs[rd][counter*NIBBLE_W +: NIBBLE_W] <= wr_nib;
        end
    end

endmodule

// File: verilog/qv_prefetch.sv
`timescale 1ns/1ps

module qv_prefetch import qv_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic [15:0]     instr_data_in,
    input  logic            instr_ready,
    input  logic            consume,
    input  logic            redirect,
    input  logic [23:1]     redirect_addr,
    output logic [XLEN-1:0] instr_word,
    output logic            instr_avail,
    output logic [23:0]     pc,
    output logic [23:1]     instr_addr,
    output logic            instr_fetch_restart,
    output logic            instr_fetch_stall
);

    logic [15:0] ring [4];
    logic [2:0]  rd_ptr;   // Extra bit tells a full ring from an empty one
    logic [2:0]  wr_ptr;
    logic [1:0]  rd_next;
    logic [2:0]  count;
    logic [23:1] base;     // Halfword address of the entry at rd_ptr
    logic        running;
    logic        boot;
    logic        accept;

    assign count             = wr_ptr - rd_ptr;
    assign rd_next           = rd_ptr[1:0] + 2'd1;
    assign instr_fetch_stall = count[2];
    assign instr_avail       = count >= 3'd2;
    assign accept = instr_ready && (running || instr_fetch_restart) && !instr_fetch_stall
                    && !redirect;

    assign instr_word = {ring[rd_next], ring[rd_ptr[1:0]]};
    assign pc         = {base, 1'b0};
    assign instr_addr = base + {20'd0, count};  // Next halfword the memory will deliver

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr              <= '0;
            wr_ptr              <= '0;
            base                <= '0;
            running             <= 1'b0;
            boot                <= 1'b1;
            instr_fetch_restart <= 1'b0;
        end else begin
            instr_fetch_restart <= boot || redirect;
            boot                <= 1'b0;
            if (redirect) begin
                // Drop whatever was buffered and follow the new stream
                rd_ptr  <= '0;
                wr_ptr  <= '0;
                base    <= redirect_addr;
                running <= 1'b0;
            end else begin
                if (instr_fetch_restart) running <= 1'b1;
                if (accept) wr_ptr <= wr_ptr + 3'd1;
                if (consume) begin
                    rd_ptr <= rd_ptr + 3'd2;
                    base   <= base + 23'd2;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) ring[wr_ptr[1:0]] <= instr_data_in;
    end

endmodule

// File: verilog/qv_decoder.sv
`timescale 1ns/1ps

module qv_decoder import qv_pkg::*; (
    input  logic [XLEN-1:0] instr_word,
    output qv_decoded_t     dec
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic            logic_f3;

    assign opcode = instr_word[6:0];
    assign funct3 = instr_word[14:12];
    assign funct7 = instr_word[31:25];

    assign imm_i = {{20{instr_word[31]}}, instr_word[31:20]};
    assign imm_s = {{20{instr_word[31]}}, instr_word[31:25], instr_word[11:7]};
    assign imm_u = {instr_word[31:12], 12'h000};
    assign imm_j = {{12{instr_word[31]}}, instr_word[19:12], instr_word[20],
                    instr_word[30:21], 1'b0};

    // ADD, XOR, OR and AND are the only funct3 codes the subset accepts
    assign logic_f3 = funct3 inside {3'b000, 3'b100, 3'b110, 3'b111};

    function automatic qv_alu_fn_e f3_to_fn(input logic [2:0] f3);
        case (f3)
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        dec.op     = OP_ILLEGAL;
        dec.alu_fn = ALU_PASS;
        dec.rs1    = instr_word[18:15];
        dec.rs2    = instr_word[23:20];
        dec.rd     = instr_word[10:7];
        dec.imm    = imm_i;

        case (opcode)
            7'b0110111: begin
                dec.op  = OP_LUI;
                dec.imm = imm_u;
            end
            7'b0010011: begin
                if (logic_f3) begin
                    dec.op     = OP_ALU_IMM;
                    dec.alu_fn = f3_to_fn(funct3);
                end
            end
            7'b0110011: begin
                if (funct7 == 7'b0000000 && logic_f3) begin
                    dec.op     = OP_ALU_REG;
                    dec.alu_fn = f3_to_fn(funct3);
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec.op     = OP_ALU_REG;
                    dec.alu_fn = ALU_SUB;
                end
            end
            7'b0000011: begin
                if (funct3 == 3'b010) begin
                    dec.op     = OP_LOAD;
                    dec.alu_fn = ALU_ADD;
                end
            end
            7'b0100011: begin
                if (funct3 == 3'b010) begin
                    dec.op     = OP_STORE;
                    dec.alu_fn = ALU_ADD;
                    dec.imm    = imm_s;
                end
            end
            7'b1101111: begin
                dec.op     = OP_JAL;
                dec.alu_fn = ALU_ADD;  // Link value is pc plus 4
                dec.imm    = imm_j;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/qv_pkg.sv
package qv_pkg;

    localparam int XLEN            = 32;
    localparam int NIBBLE_W        = 4;
    localparam int NUM_PASS_CYCLES = 8;

    typedef logic [NIBBLE_W-1:0] qv_nibble_t;

    // Instruction classes as seen by control
    typedef enum logic [2:0] {
        OP_LUI,
        OP_ALU_IMM,
        OP_ALU_REG,
        OP_LOAD,
        OP_STORE,
        OP_JAL,
        OP_ILLEGAL
    } qv_op_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS  // Passes the b operand through
    } qv_alu_fn_e;

    typedef struct packed {
        qv_op_e           op;
        qv_alu_fn_e       alu_fn;
        logic [3:0]       rs1;
        logic [3:0]       rs2;
        logic [3:0]       rd;
        logic [XLEN-1:0]  imm;
    } qv_decoded_t;

endpackage
